/* vlog.f */
+incdir+.
tweezer_pkg.sv
param_bank.sv
sample_frontend.sv
feedback_sequencer.sv
pi_datapath.sv
tweezer_feedback_top.sv
tb_tweezer_feedback.sv

/* Makefile */
TOP = tb_tweezer_feedback

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* tb_tweezer_feedback.sv */
`timescale 1ns/1ps
`include "tweezer_settings.svh"

module tb_tweezer_feedback;

    localparam int clk_period = 20;
    // cycle budget per test, reset and tests one to five
    localparam int test_cycles = 40 + 200 + 160 + 100 + 40;

    logic                        clk_adc;
    logic                        reset;
    logic                        param_req;
    tweezer_pkg::param_write_t   param_write;
    logic                        param_ack;
    tweezer_pkg::adc_frame_t     adc_frame;
    logic                        sample_valid;
    logic [1:0]                  channel_select;
    logic                        pi_enable;
    logic                        pi_reset;
    logic signed [`SAMPLE_W-1:0] controller_out;
    logic [`SAMPLE_W-1:0]        dac_code;
    logic                        out_valid;
    logic [`N_CHANNELS-1:0]      saturated;
    logic                        overrun;

    // model view of the register bank
    logic signed [`COEFF_W-1:0]  kp_m;
    logic signed [`COEFF_W-1:0]  ki_m;
    logic signed [`SAMPLE_W-1:0] setpoint_m;
    logic signed [`SAMPLE_W-1:0] limit_hi_m;
    logic signed [`SAMPLE_W-1:0] limit_lo_m;
    logic signed [`SAMPLE_W-1:0] out_disabled_m;
    logic signed [`SAMPLE_W-1:0] x_offset_m;
    // model integrator
    longint                      integ_m;
    logic [31:0]                 rng_state;

    tweezer_feedback_top uut (.*);

    initial begin
        clk_adc = 1'b0;
        forever #(clk_period / 2) clk_adc = ~clk_adc;
    end

    // hang guard, twice the expected run length
    initial begin
        #(2 * test_cycles * clk_period);
        $display("timeout: the tests did not finish in the expected time");
        $display("Checks failed");
        $fatal(1);
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic tweezer_pkg::adc_frame_t make_frame(input logic [15:0] a,
        input logic [15:0] b, input logic [15:0] c, input logic [15:0] d);
        tweezer_pkg::adc_frame_t f;
        f.ch_a = a;
        f.ch_b = b;
        f.ch_c = c;
        f.ch_d = d;
        return f;
    endfunction

    function automatic tweezer_pkg::adc_frame_t random_frame();
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = next_random();
        r1 = next_random();
        return make_frame(r0[15:0], r0[31:16], r1[15:0], r1[31:16]);
    endfunction

    // rail flags, bit 0 is channel a
    function automatic logic [3:0] rail_flags(input tweezer_pkg::adc_frame_t f);
        logic [3:0] flags;
        flags[0] = (f.ch_a == 16'h7fff) || (f.ch_a == 16'h8000);
        flags[1] = (f.ch_b == 16'h7fff) || (f.ch_b == 16'h8000);
        flags[2] = (f.ch_c == 16'h7fff) || (f.ch_c == 16'h8000);
        flags[3] = (f.ch_d == 16'h7fff) || (f.ch_d == 16'h8000);
        return flags;
    endfunction

    function automatic longint saturate(input longint v);
        if (v > 32767) begin
            return 32767;
        end else if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    function automatic longint limit(input longint v);
        longint hi;
        longint lo;
        hi = limit_hi_m;
        lo = limit_lo_m;
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    // mirror of a host write, split halves land alone
    function automatic void apply_to_model(input logic [3:0] idx, input logic [15:0] data);
        case (idx)
            tweezer_pkg::KP_LO: kp_m[15:0] = data;
            tweezer_pkg::KP_HI: kp_m[`COEFF_W-1:16] = data[`COEFF_W-17:0];
            tweezer_pkg::KI_LO: ki_m[15:0] = data;
            tweezer_pkg::KI_HI: ki_m[`COEFF_W-1:16] = data[`COEFF_W-17:0];
            tweezer_pkg::SETPOINT: setpoint_m = data;
            tweezer_pkg::LIMIT_HI: limit_hi_m = data;
            tweezer_pkg::LIMIT_LO: limit_lo_m = data;
            tweezer_pkg::OUT_DISABLED: out_disabled_m = data;
            tweezer_pkg::X_OFFSET: x_offset_m = data;
            default: begin
            end
        endcase
    endfunction

    // one pi step on the model, expected controller output
    task automatic model_step(input tweezer_pkg::adc_frame_t f,
                              output logic signed [`SAMPLE_W-1:0] expected);
        logic signed [`SAMPLE_W-1:0] chan;
        longint pos;
        longint err;
        longint prop;
        longint iterm;
        longint total;
        // 0 picks channel d, 3 picks a
        case (channel_select)
            2'd0: chan = f.ch_d;
            2'd1: chan = f.ch_c;
            2'd2: chan = f.ch_b;
            default: chan = f.ch_a;
        endcase
        pos = saturate(longint'(chan) - longint'(x_offset_m));
        err = saturate(longint'(setpoint_m) - pos);
        prop = (longint'(kp_m) * err) >>> `COEFF_FRAC;
        iterm = (longint'(ki_m) * err) >>> `COEFF_FRAC;
        if (!pi_enable) begin
            integ_m = 0;
            expected = out_disabled_m;
        end else begin
            integ_m = pi_reset ? 0 : limit(integ_m + iterm);
            total = limit(prop + integ_m);
            expected = total[`SAMPLE_W-1:0];
        end
    endtask

    // four-phase write, callers start 2 ns after an edge
    task automatic write_param(input logic [3:0] idx, input logic [15:0] data);
        int waited;
        param_write = {idx, data};
        param_req = 1'b1;
        waited = 0;
        do begin
            @(posedge clk_adc);
            #2;
            waited++;
        end while (!param_ack && waited < 16);
        if (!param_ack) begin
            $display("no ack from parameter bank at %0t", $time);
            $display("Checks failed");
            $fatal(1);
        end
        param_req = 1'b0;
        waited = 0;
        do begin
            @(posedge clk_adc);
            #2;
            waited++;
        end while (param_ack && waited < 16);
        if (param_ack) begin
            $display("parameter bank kept ack high after req dropped at %0t", $time);
            $display("Checks failed");
            $fatal(1);
        end
        apply_to_model(idx, data);
    endtask

    task automatic send_sample(input tweezer_pkg::adc_frame_t f);
        logic signed [`SAMPLE_W-1:0] expected;
        model_step(f, expected);
        adc_frame = f;
        sample_valid = 1'b1;
        @(posedge clk_adc);
        #2;
        sample_valid = 1'b0;
        repeat (`PI_LATENCY - 1) @(posedge clk_adc);
        #2;
        check_eq(out_valid, 1'b0, "out_valid one cycle early");
        @(posedge clk_adc);
        #2;
        check_eq(out_valid, 1'b1, "out_valid after the sample latency");
        check_eq(controller_out, expected, "controller_out");
        check_eq(dac_code, expected ^ 16'h8000, "dac_code");
    endtask

    task automatic test_reset_disabled();
        check_eq(param_ack, 1'b0, "param_ack after reset");
        check_eq(out_valid, 1'b0, "out_valid after reset");
        check_eq(overrun, 1'b0, "overrun after reset");
        check_eq(controller_out, 16'h0000, "controller_out after reset");
        check_eq(dac_code, 16'h0000, "dac_code after reset");
        pi_enable = 1'b0;
        write_param(tweezer_pkg::OUT_DISABLED, 16'h1234);
        repeat (2) send_sample(random_frame());
        write_param(tweezer_pkg::OUT_DISABLED, 16'hc001);
        send_sample(random_frame());
    endtask

    task automatic test_handshake_proportional();
        pi_enable = 1'b1;
        channel_select = 2'd0;
        // exact ack timing on one write
        param_write = {tweezer_pkg::SETPOINT, 16'h0100};
        param_req = 1'b1;
        @(posedge clk_adc);
        #2;
        check_eq(param_ack, 1'b1, "ack one cycle after req");
        @(posedge clk_adc);
        #2;
        check_eq(param_ack, 1'b1, "ack held while req high");
        param_req = 1'b0;
        @(posedge clk_adc);
        #2;
        check_eq(param_ack, 1'b0, "ack released after req low");
        apply_to_model(tweezer_pkg::SETPOINT, 16'h0100);
        // low half alone, high half still zero
        write_param(tweezer_pkg::KP_LO, 16'ha3c5);
        send_sample(random_frame());
        write_param(tweezer_pkg::KP_HI, 16'h0014);
        // unmapped index
        write_param(4'd12, 16'hffff);
        repeat (20) send_sample(random_frame());
    endtask

    task automatic test_integral_limits();
        write_param(tweezer_pkg::KP_LO, 16'h0000);
        write_param(tweezer_pkg::KP_HI, 16'h0000);
        // ki 0.5
        write_param(tweezer_pkg::KI_LO, 16'h0000);
        write_param(tweezer_pkg::KI_HI, 16'h0080);
        write_param(tweezer_pkg::LIMIT_HI, 16'h0200);
        write_param(tweezer_pkg::LIMIT_LO, 16'hfe80);
        // kp zero, output is the integrator, climbs to the high limit
        repeat (5) send_sample(make_frame(0, 0, 0, 0));
        // then down to the low limit
        repeat (5) send_sample(make_frame(16'h0300, 16'h0300, 16'h0300, 16'h0300));
        pi_reset = 1'b1;
        send_sample(make_frame(0, 0, 0, 0));
        pi_reset = 1'b0;
        // restarts from zero
        send_sample(make_frame(0, 0, 0, 0));
        // proportional plus integral, output clamp
        write_param(tweezer_pkg::KP_LO, 16'ha3c5);
        write_param(tweezer_pkg::KP_HI, 16'h0014);
        repeat (3) send_sample(make_frame(0, 0, 0, 0));
    endtask

    task automatic test_channels_saturation();
        tweezer_pkg::adc_frame_t f;
        // kp 1.0, ki off, full range
        write_param(tweezer_pkg::KP_LO, 16'h0000);
        write_param(tweezer_pkg::KP_HI, 16'h0100);
        write_param(tweezer_pkg::KI_HI, 16'h0000);
        write_param(tweezer_pkg::LIMIT_HI, 16'h7fff);
        write_param(tweezer_pkg::LIMIT_LO, 16'h8000);
        write_param(tweezer_pkg::SETPOINT, 16'h0000);
        write_param(tweezer_pkg::X_OFFSET, 16'h0050);
        f = make_frame(16'h1111, 16'h2222, 16'hfccd, 16'h0444);
        for (int sel = 0; sel < 4; sel++) begin
            channel_select = sel[1:0];
            send_sample(f);
            check_eq(saturated, 4'b0000, "no channel at a rail");
        end
        // selected channel at the negative rail, offset pushes past it
        f = make_frame(16'h7fff, 16'h0123, 16'h8000, 16'h0456);
        channel_select = 2'd1;
        send_sample(f);
        check_eq(saturated, rail_flags(f), "saturated flags a and c");
        f = make_frame(16'h0001, 16'h8000, 16'h0002, 16'h7fff);
        channel_select = 2'd3;
        send_sample(f);
        check_eq(saturated, rail_flags(f), "saturated flags b and d");
    endtask

    task automatic test_overrun();
        tweezer_pkg::adc_frame_t f1;
        tweezer_pkg::adc_frame_t f2;
        logic signed [`SAMPLE_W-1:0] expected;
        int seen;
        check_eq(overrun, 1'b0, "overrun before the test");
        f1 = random_frame();
        f2 = random_frame();
        model_step(f1, expected);
        adc_frame = f1;
        sample_valid = 1'b1;
        @(posedge clk_adc);
        #2;
        sample_valid = 1'b0;
        @(posedge clk_adc);
        #2;
        // second sample while the sequencer is busy
        adc_frame = f2;
        sample_valid = 1'b1;
        @(posedge clk_adc);
        #2;
        sample_valid = 1'b0;
        seen = 0;
        repeat (8) begin
            @(posedge clk_adc);
            #2;
            if (out_valid) begin
                seen++;
                check_eq(controller_out, expected, "result of the first sample");
            end
        end
        check_eq(seen, 1, "out_valid count with an overrun");
        check_eq(overrun, 1'b1, "overrun flag");
        send_sample(random_frame());
        check_eq(overrun, 1'b1, "overrun stays set");
    endtask

    initial begin
        rng_state = 32'hce3c181a;
        reset = 1'b1;
        param_req = 1'b0;
        param_write = '0;
        adc_frame = '0;
        sample_valid = 1'b0;
        channel_select = 2'd0;
        pi_enable = 1'b0;
        pi_reset = 1'b0;
        // model starts at the reset values
        kp_m = '0;
        ki_m = '0;
        setpoint_m = '0;
        limit_hi_m = `LIMIT_HI_RESET;
        limit_lo_m = `LIMIT_LO_RESET;
        out_disabled_m = '0;
        x_offset_m = '0;
        integ_m = 0;
        repeat (3) @(posedge clk_adc);
        #2;
        reset = 1'b0;
        test_reset_disabled();
        test_handshake_proportional();
        test_integral_limits();
        test_channels_saturation();
        test_overrun();
        $display("All checks passed");
        $finish;
    end

endmodule

/* tweezer_feedback_top.sv */
`timescale 1ns/1ps
`include "tweezer_settings.svh"

module tweezer_feedback_top (
    input  logic                        clk_adc,
    input  logic                        reset,
    input  logic                        param_req,
    input  tweezer_pkg::param_write_t   param_write,
    output logic                        param_ack,
    input  tweezer_pkg::adc_frame_t     adc_frame,
    input  logic                        sample_valid,
    input  logic [1:0]                  channel_select,
    input  logic                        pi_enable,
    input  logic                        pi_reset,
    output logic signed [`SAMPLE_W-1:0] controller_out,
    output logic [`SAMPLE_W-1:0]        dac_code,
    output logic                        out_valid,
    output logic [`N_CHANNELS-1:0]      saturated,
    output logic                        overrun
);

    tweezer_pkg::pi_config_t     pi_config;
    tweezer_pkg::pi_cmd_t        pi_cmd;
    logic signed [`SAMPLE_W-1:0] position;
    logic                        pos_valid;

    // host registers
    param_bank u_param_bank (
        .clk_adc     (clk_adc),
        .reset       (reset),
        .param_req   (param_req),
        .param_write (param_write),
        .param_ack   (param_ack),
        .pi_config   (pi_config)
    );

    // channel pick and offset
    sample_frontend u_sample_frontend (
        .clk_adc        (clk_adc),
        .reset          (reset),
        .adc_frame      (adc_frame),
        .sample_valid   (sample_valid),
        .channel_select (channel_select),
        .x_offset       (pi_config.x_offset),
        .position       (position),
        .pos_valid      (pos_valid),
        .saturated      (saturated)
    );

    feedback_sequencer u_feedback_sequencer (
        .clk_adc   (clk_adc),
        .reset     (reset),
        .pos_valid (pos_valid),
        .pi_cmd    (pi_cmd),
        .overrun   (overrun)
    );

    pi_datapath u_pi_datapath (
        .clk_adc        (clk_adc),
        .reset          (reset),
        .pi_cmd         (pi_cmd),
        .position       (position),
        .pi_config      (pi_config),
        .pi_enable      (pi_enable),
        .pi_reset       (pi_reset),
        .controller_out (controller_out),
        .dac_code       (dac_code),
        .out_valid      (out_valid)
    );

endmodule

/* pi_datapath.sv */
`timescale 1ns/1ps
`include "tweezer_settings.svh"

module pi_datapath (
    input  logic                        clk_adc,
    input  logic                        reset,
    input  tweezer_pkg::pi_cmd_t        pi_cmd,
    input  logic signed [`SAMPLE_W-1:0] position,
    input  tweezer_pkg::pi_config_t     pi_config,
    input  logic                        pi_enable,
    input  logic                        pi_reset,
    output logic signed [`SAMPLE_W-1:0] controller_out,
    output logic [`SAMPLE_W-1:0]        dac_code,
    output logic                        out_valid
);

    localparam int prod_w = `COEFF_W + `SAMPLE_W;

    localparam logic signed [`SAMPLE_W-1:0] full_pos = {1'b0, {(`SAMPLE_W-1){1'b1}}};
    localparam logic signed [`SAMPLE_W-1:0] full_neg = {1'b1, {(`SAMPLE_W-1){1'b0}}};

    logic signed [`SAMPLE_W:0]   error_diff;
    logic signed [`SAMPLE_W-1:0] error_q;
    logic signed [prod_w-1:0]    kp_shift;
    logic signed [prod_w-1:0]    ki_shift;
    logic signed [`ACC_W-1:0]    prop_q;
    logic signed [`ACC_W-1:0]    ki_term_q;
    logic signed [`ACC_W-1:0]    integrator;
    logic signed [`ACC_W-1:0]    integ_next;
    logic signed [`ACC_W-1:0]    out_clamped;
    logic signed [`SAMPLE_W-1:0] out_next;

    // bound a working value by the output limits
    function automatic logic signed [`ACC_W-1:0] clamp_to_limits(
        input logic signed [`ACC_W-1:0]    value,
        input logic signed [`SAMPLE_W-1:0] hi,
        input logic signed [`SAMPLE_W-1:0] lo
    );
        if (value > hi) begin
            return hi;
        end else if (value < lo) begin
            return lo;
        end
        return value;
    endfunction

    // setpoint minus position, saturated back to a sample word
    assign error_diff = pi_config.setpoint - position;

    // products back to integer scale
    assign kp_shift = (pi_config.kp * error_q) >>> `COEFF_FRAC;
    assign ki_shift = (pi_config.ki * error_q) >>> `COEFF_FRAC;

    // integrator step, cleared outright by pi_reset
    always_comb begin
        if (pi_reset) begin
            integ_next = '0;
        end else begin
            integ_next = clamp_to_limits(integrator + ki_term_q,
                                         pi_config.limit_hi, pi_config.limit_lo);
        end
        // output uses the integrator value being written this step
        out_clamped = clamp_to_limits(prop_q + integ_next,
                                      pi_config.limit_hi, pi_config.limit_lo);
        out_next = pi_enable ? out_clamped[`SAMPLE_W-1:0] : pi_config.out_disabled;
    end

    // working registers, each loaded on its strobe
    always_ff @(posedge clk_adc) begin
        if (pi_cmd.load_error) begin
            if (error_diff > full_pos) begin
                error_q <= full_pos;
            end else if (error_diff < full_neg) begin
                error_q <= full_neg;
            end else begin
                error_q <= error_diff[`SAMPLE_W-1:0];
            end
        end
        if (pi_cmd.load_products) begin
            prop_q    <= kp_shift[`ACC_W-1:0];
            ki_term_q <= ki_shift[`ACC_W-1:0];
        end
    end

    // integrator parked at zero while the loop is off
    always_ff @(posedge clk_adc) begin
        if (reset || !pi_enable) begin
            integrator <= '0;
        end else if (pi_cmd.update_output) begin
            integrator <= integ_next;
        end
    end

    // result and offset-binary dac code
    always_ff @(posedge clk_adc) begin
        if (reset) begin
            controller_out <= '0;
            dac_code       <= '0;
            out_valid      <= 1'b0;
        end else begin
            out_valid <= pi_cmd.update_output;
            if (pi_cmd.update_output) begin
                controller_out <= out_next;
                dac_code       <= {~out_next[`SAMPLE_W-1], out_next[`SAMPLE_W-2:0]};
            end
        end
    end

    a_out_in_limits: assert property (
        @(posedge clk_adc) disable iff (reset)
        out_valid && $past(pi_enable) && $stable(pi_config)
            && (pi_config.limit_lo <= pi_config.limit_hi)
        |-> (controller_out >= pi_config.limit_lo) && (controller_out <= pi_config.limit_hi)
    );

endmodule

/* feedback_sequencer.sv */
`timescale 1ns/1ps
`include "tweezer_settings.svh"

module feedback_sequencer (
    input  logic                 clk_adc,
    input  logic                 reset,
    input  logic                 pos_valid,
    output tweezer_pkg::pi_cmd_t pi_cmd,
    output logic                 overrun
);

    tweezer_pkg::pi_step_e state;
    tweezer_pkg::pi_step_e state_next;

    // sample only starts a pass from idle
    logic accept;

    assign accept = pos_valid && (state == tweezer_pkg::IDLE);

    // fixed walk idle, error, product, update
    always_comb begin
        case (state)
            tweezer_pkg::IDLE: begin
                state_next = accept ? tweezer_pkg::ERROR : tweezer_pkg::IDLE;
            end
            tweezer_pkg::ERROR: begin
                state_next = tweezer_pkg::PRODUCT;
            end
            tweezer_pkg::PRODUCT: begin
                state_next = tweezer_pkg::UPDATE;
            end
            tweezer_pkg::UPDATE: begin
                state_next = tweezer_pkg::IDLE;
            end
            default: begin
                state_next = tweezer_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_adc) begin
        if (reset) begin
            state   <= tweezer_pkg::IDLE;
            overrun <= 1'b0;
        end else begin
            state <= state_next;
            // sample lost while busy, sticky until reset
            if (pos_valid && !accept) begin
                overrun <= 1'b1;
            end
        end
    end

    // strobes decoded straight from the state
    assign pi_cmd.load_error    = (state == tweezer_pkg::ERROR);
    assign pi_cmd.load_products = (state == tweezer_pkg::PRODUCT);
    assign pi_cmd.update_output = (state == tweezer_pkg::UPDATE);

    a_one_strobe: assert property (
        @(posedge clk_adc) disable iff (reset)
        $onehot0(pi_cmd)
    );

endmodule

/* sample_frontend.sv */
`timescale 1ns/1ps
`include "tweezer_settings.svh"

module sample_frontend (
    input  logic                        clk_adc,
    input  logic                        reset,
    input  tweezer_pkg::adc_frame_t     adc_frame,
    input  logic                        sample_valid,
    input  logic [1:0]                  channel_select,
    input  logic signed [`SAMPLE_W-1:0] x_offset,
    output logic signed [`SAMPLE_W-1:0] position,
    output logic                        pos_valid,
    output logic [`N_CHANNELS-1:0]      saturated
);

    // full-scale codes of the adc
    localparam logic signed [`SAMPLE_W-1:0] full_pos = {1'b0, {(`SAMPLE_W-1){1'b1}}};
    localparam logic signed [`SAMPLE_W-1:0] full_neg = {1'b1, {(`SAMPLE_W-1){1'b0}}};

    tweezer_pkg::adc_frame_t              frame_q;
    logic [`N_CHANNELS-1:0][`SAMPLE_W-1:0] chans;
    logic signed [`SAMPLE_W-1:0]          selected;
    logic signed [`SAMPLE_W:0]            diff;

    // frame is held until the next valid sample
    always_ff @(posedge clk_adc) begin
        if (reset) begin
            frame_q   <= '0;
            pos_valid <= 1'b0;
        end else begin
            pos_valid <= sample_valid;
            if (sample_valid) begin
                frame_q <= adc_frame;
            end
        end
    end

    // same frame viewed as an array, index 0 is channel a
    assign chans = frame_q;

    // per-channel flag when stuck at either rail
    always_comb begin
        for (int i = 0; i < `N_CHANNELS; i++) begin
            saturated[i] = (chans[i] == full_pos) || (chans[i] == full_neg);
        end
    end

    // board wiring has the channel order reversed
    always_comb begin
        case (channel_select)
            2'd0: selected = frame_q.ch_d;
            2'd1: selected = frame_q.ch_c;
            2'd2: selected = frame_q.ch_b;
            2'd3: selected = frame_q.ch_a;
        endcase
    end

    // one extra bit so the offset cannot wrap
    assign diff = selected - x_offset;

    always_comb begin
        if (diff > full_pos) begin
            position = full_pos;
        end else if (diff < full_neg) begin
            position = full_neg;
        end else begin
            position = diff[`SAMPLE_W-1:0];
        end
    end

endmodule

/* param_bank.sv */
`timescale 1ns/1ps
`include "tweezer_settings.svh"

module param_bank (
    input  logic                    clk_adc,
    input  logic                    reset,
    input  logic                    param_req,
    input  tweezer_pkg::param_write_t param_write,
    output logic                    param_ack,
    output tweezer_pkg::pi_config_t pi_config
);

    // write strobe, first cycle of a new request only
    logic write_en;

    // request seen while ack is still low
    assign write_en = param_req && !param_ack;

    // ack side of the four-phase handshake
    always_ff @(posedge clk_adc) begin
        if (reset) begin
            param_ack <= 1'b0;
        end else if (write_en) begin
            // raise once the register is written
            param_ack <= 1'b1;
        end else if (!param_req) begin
            // host has dropped req, release ack
            param_ack <= 1'b0;
        end
    end

    // register file
    always_ff @(posedge clk_adc) begin
        if (reset) begin
            pi_config.kp           <= '0;
            pi_config.ki           <= '0;
            pi_config.setpoint     <= '0;
            pi_config.limit_hi     <= `LIMIT_HI_RESET;
            pi_config.limit_lo     <= `LIMIT_LO_RESET;
            pi_config.out_disabled <= '0;
            pi_config.x_offset     <= '0;
        end else if (write_en) begin
            case (param_write.index)
                // each half lands on its own, the other half keeps its value
                tweezer_pkg::KP_LO: begin
                    pi_config.kp[15:0] <= param_write.data;
                end
                tweezer_pkg::KP_HI: begin
                    pi_config.kp[`COEFF_W-1:16] <= param_write.data[`COEFF_W-17:0];
                end
                tweezer_pkg::KI_LO: begin
                    pi_config.ki[15:0] <= param_write.data;
                end
                tweezer_pkg::KI_HI: begin
                    pi_config.ki[`COEFF_W-1:16] <= param_write.data[`COEFF_W-17:0];
                end
                // single word registers
                tweezer_pkg::SETPOINT: begin
                    pi_config.setpoint <= param_write.data;
                end
                tweezer_pkg::LIMIT_HI: begin
                    pi_config.limit_hi <= param_write.data;
                end
                tweezer_pkg::LIMIT_LO: begin
                    pi_config.limit_lo <= param_write.data;
                end
                tweezer_pkg::OUT_DISABLED: begin
                    pi_config.out_disabled <= param_write.data;
                end
                tweezer_pkg::X_OFFSET: begin
                    pi_config.x_offset <= param_write.data;
                end
                // unmapped index, acked but nothing stored
                default: begin
                end
            endcase
        end
    end

    // ack only ever answers a pending request
    a_ack_needs_req: assert property (
        @(posedge clk_adc) disable iff (reset)
        $rose(param_ack) |-> $past(param_req)
    );

endmodule

/* tweezer_pkg.sv */
`include "tweezer_settings.svh"

package tweezer_pkg;

    // host register map
    // wide coefficients take two indexes, low half first
    typedef enum logic [3:0] {
        KP_LO        = 4'd0,
        KP_HI        = 4'd1,
        KI_LO        = 4'd2,
        KI_HI        = 4'd3,
        SETPOINT     = 4'd4,
        LIMIT_HI     = 4'd5,
        LIMIT_LO     = 4'd6,
        OUT_DISABLED = 4'd7,
        X_OFFSET     = 4'd8
    } param_index_e;

    // one host write, index plus 16 bit word
    typedef struct packed {
        param_index_e index;
        logic [15:0]  data;
    } param_write_t;

    // live controller parameters
    typedef struct packed {
        logic signed [`COEFF_W-1:0]  kp;
        logic signed [`COEFF_W-1:0]  ki;
        logic signed [`SAMPLE_W-1:0] setpoint;
        logic signed [`SAMPLE_W-1:0] limit_hi;
        logic signed [`SAMPLE_W-1:0] limit_lo;
        logic signed [`SAMPLE_W-1:0] out_disabled;
        logic signed [`SAMPLE_W-1:0] x_offset;
    } pi_config_t;

    // one adc conversion, channel a in the low bits
    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] ch_d;
        logic signed [`SAMPLE_W-1:0] ch_c;
        logic signed [`SAMPLE_W-1:0] ch_b;
        logic signed [`SAMPLE_W-1:0] ch_a;
    } adc_frame_t;

    // sequencer steps, one per cycle after an accepted sample
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ERROR   = 2'd1,
        PRODUCT = 2'd2,
        UPDATE  = 2'd3
    } pi_step_e;

    // datapath strobes, at most one high per cycle
    typedef struct packed {
        logic load_error;
        logic load_products;
        logic update_output;
    } pi_cmd_t;

endpackage

/* tweezer_settings.svh */
`ifndef TWEEZER_SETTINGS_SVH
`define TWEEZER_SETTINGS_SVH

// adc sample and controller word
`define SAMPLE_W 16

// pi coefficients, signed q2.24
`define COEFF_W 26
`define COEFF_FRAC 24

// integrator word, wide enough for the shifted products
`define ACC_W 28

// adc channels a to d
`define N_CHANNELS 4

// sample_valid to out_valid, in clk_adc cycles
`define PI_LATENCY 4

// limits after reset, the whole signed range
`define LIMIT_HI_RESET 16'sh7fff
`define LIMIT_LO_RESET 16'sh8000

`endif
